// ==== hdl/busPkg.sv ====
package busPkg;

    localparam int NumSenders = 11;         // Bus masters
    localparam int NumRecv    = 9;          // Receivers
    localparam int QueueDepth = 4;          // Request entries held
    localparam int SenderIdx  = 4;
    localparam int RecvIdx    = 4;
    localparam int PtrW       = $clog2(QueueDepth);
    localparam int CountW     = PtrW + 1;

    // Entry i is the node code of sender i, and a higher i wins arbitration
    localparam logic [SenderIdx-1:0] SenderCode [NumSenders] = '{
        4'hB,                               // Bank3
        4'hA,                               // Bank2
        4'h9,                               // Bank1
        4'h8,                               // Bank0
        4'h7,                               // D-cache odd write
        4'h5,                               // D-cache even write
        4'h6,                               // D-cache odd read
        4'h4,                               // D-cache even read
        4'h1,                               // I-cache odd read
        4'h0,                               // I-cache even read
        4'hC                                // DMA and IO
    };

    // One queued transfer request
    typedef struct packed {
        logic [SenderIdx-1:0] sender;       // Node code from SenderCode
        logic [RecvIdx-1:0]   dest;         // Receiver index, 0 to NumRecv-1
    } busReq_t;

endpackage

// ==== hdl/busReqQueue.sv ====
`timescale 1ns/1ns

module busReqQueue import busPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NumSenders-1:0] req,
    input  logic [RecvIdx-1:0]    reqDest [NumSenders],
    input  logic [NumRecv-1:0]    free,
    input  logic                  pull,
    output logic [NumSenders-1:0] ack,
    output busReq_t               head,
    output logic                  headReady
);

    busReq_t               mem [QueueDepth];
    logic [PtrW-1:0]       wrPtr;
    logic [PtrW-1:0]       rdPtr;
    logic [CountW-1:0]     count;
    logic                  full;
    logic                  empty;

    logic [NumSenders-1:0] cand;
    logic [NumSenders-1:0] pickOh;
    busReq_t               pickEntry;
    logic                  push;
    logic                  pop;
    logic                  headFree;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        logic [PtrW-1:0] res;
        if (ptr == PtrW'(QueueDepth - 1)) begin
            res = '0;
        end else begin
            res = ptr + 1'b1;
        end
        return res;
    endfunction

    assign full  = (count == CountW'(QueueDepth));
    assign empty = (count == '0);

    // A sender seeing its ack now is already queued and still holds req
    assign cand = req & ~ack;

    // Fixed priority, the highest index wins
    always_comb begin
        pickOh    = '0;
        pickEntry = '0;
        for (int i = 0; i < NumSenders; i++) begin
            if (cand[i]) begin
                pickOh           = '0;
                pickOh[i]        = 1'b1;
                pickEntry.sender = SenderCode[i];   // Tag with the bus node code
                pickEntry.dest   = reqDest[i];
            end
        end
    end

    assign push = !full && (cand != '0);
    assign pop  = pull && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pickEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            ack   <= '0;
        end else begin
            ack <= push ? pickOh : '0;              // One-cycle pulse to the captured sender
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle, or push and pop together
            endcase
        end
    end

    assign head = mem[rdPtr];

    // Free level of the head's receiver
    always_comb begin
        headFree = 1'b0;
        for (int j = 0; j < NumRecv; j++) begin
            if (head.dest == RecvIdx'(j)) begin
                headFree = free[j];
            end
        end
    end

    // A busy receiver at the head blocks everything behind it
    assign headReady = !empty && headFree;

endmodule

// ==== hdl/busAllocator.sv ====
`timescale 1ns/1ns

module busAllocator import busPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  busReq_t               head,
    input  logic                  headReady,
    input  logic [NumSenders-1:0] rel,
    output logic                  pull,
    output logic [NumSenders-1:0] grant,
    output logic [NumRecv-1:0]    recv
);

    logic    busy;                              // Low is idle, high is busy
    busReq_t owner;
    logic    accept;
    logic    ownerRel;

    // Take the head as soon as the bus is idle
    assign accept = !busy && headReady;
    assign pull   = accept;

    // Map the owner's node code back to its grant line
    always_comb begin
        grant = '0;
        for (int i = 0; i < NumSenders; i++) begin
            if (busy && owner.sender == SenderCode[i]) begin
                grant[i] = 1'b1;
            end
        end
    end

    always_comb begin
        recv = '0;
        for (int j = 0; j < NumRecv; j++) begin
            if (busy && owner.dest == RecvIdx'(j)) begin
                recv[j] = 1'b1;
            end
        end
    end

    // Releases from masters without the bus are ignored
    assign ownerRel = busy && ((rel & grant) != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (ownerRel) begin
            busy <= 1'b0;                       // Idle again in the next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            owner <= head;
        end
    end

endmodule

// ==== hdl/busTop.sv ====
`timescale 1ns/1ns

module busTop import busPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NumSenders-1:0] req,
    input  logic [RecvIdx-1:0]    reqDest [NumSenders],
    input  logic [NumRecv-1:0]    free,
    input  logic [NumSenders-1:0] rel,
    output logic [NumSenders-1:0] ack,
    output logic [NumSenders-1:0] grant,
    output logic [NumRecv-1:0]    recv
);

    busReq_t head;                              // Oldest queued request
    logic    headReady;                         // Queue not empty and head's receiver free
    logic    pull;                              // Pops the head

    busReqQueue i_queue (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .reqDest   (reqDest),
        .free      (free),
        .pull      (pull),
        .ack       (ack),
        .head      (head),
        .headReady (headReady)
    );

    busAllocator i_alloc (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .headReady (headReady),
        .rel       (rel),
        .pull      (pull),
        .grant     (grant),
        .recv      (recv)
    );

endmodule

// ==== test/busTop_assert.sv ====
`timescale 1ns/1ns

module busTopAssert import busPkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [NumSenders-1:0] req,
    input logic [RecvIdx-1:0]    reqDest [NumSenders],
    input logic [NumRecv-1:0]    free,
    input logic [NumSenders-1:0] rel,
    input logic [NumSenders-1:0] ack,
    input logic [NumSenders-1:0] grant,
    input logic [NumRecv-1:0]    recv
);

    logic [NumSenders-1:0] prevCand;            // Requests not acked in the last cycle
    logic [NumSenders-1:0] prevGrant;
    logic [NumSenders-1:0] prevRel;
    logic [NumRecv-1:0]    prevFree;
    logic [NumRecv-1:0]    prevRecv;
    logic [RecvIdx-1:0]    prevDest [NumSenders];
    logic [SenderIdx-1:0]  orderSender [16];    // Acked senders in arrival order
    logic [RecvIdx-1:0]    orderDest [16];
    logic [3:0]            wrIdx;
    logic [3:0]            rdIdx;
    logic [3:0]            waiting;
    logic                  grantRise;
    logic [NumSenders-1:0] expAck;
    logic [NumSenders-1:0] expGrant;
    logic [NumRecv-1:0]    expRecv;
    logic [NumSenders-1:0] expHold;
    int                    failCount = 0;

    // Highest index among the pending requests
    function automatic logic [NumSenders-1:0] topRequest(input logic [NumSenders-1:0] v);
        logic [NumSenders-1:0] res;
        res = '0;
        for (int i = NumSenders - 1; i >= 0; i--) begin
            if (v[i] && res == '0) begin
                res[i] = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic logic [SenderIdx-1:0] ohIndex(input logic [NumSenders-1:0] oh);
        logic [SenderIdx-1:0] idx;
        idx = '0;
        for (int i = 0; i < NumSenders; i++) begin
            if (oh[i]) begin
                idx = SenderIdx'(i);
            end
        end
        return idx;
    endfunction

    assign waiting   = wrIdx - rdIdx;           // Entries acked but not yet granted
    assign grantRise = (grant != '0) && (prevGrant == '0);
    assign expAck    = (waiting < QueueDepth) ? topRequest(prevCand) : '0;
    assign expGrant  = NumSenders'(1) << orderSender[rdIdx];
    assign expRecv   = NumRecv'(1) << orderDest[rdIdx];
    assign expHold   = ((prevRel & prevGrant) != '0) ? '0 : prevGrant;

    always_ff @(posedge clk) begin
        prevDest <= reqDest;
        if (rst) begin
            prevCand  <= '0;
            prevGrant <= '0;
            prevRel   <= '0;
            prevFree  <= '0;
            prevRecv  <= '0;
            wrIdx     <= '0;
            rdIdx     <= '0;
        end else begin
            prevCand  <= req & ~ack;
            prevGrant <= grant;
            prevRel   <= rel;
            prevFree  <= free;
            prevRecv  <= recv;
            if (ack != '0) begin
                orderSender[wrIdx] <= ohIndex(ack);
                orderDest[wrIdx]   <= prevDest[ohIndex(ack)];   // Dest held at capture
                wrIdx              <= wrIdx + 1'b1;
            end
            if (grantRise) begin
                rdIdx <= rdIdx + 1'b1;
            end
        end
    end

    a_oneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ack) && $onehot0(grant) && $onehot0(recv))
        else begin
            failCount++;
            $error("CHECK FAILED ack=%h grant=%h recv=%h more than one bit", ack, grant, recv);
        end

    a_ackPick: assert property (@(posedge clk) disable iff (rst) ack == expAck)
        else begin
            failCount++;
            $error("CHECK FAILED ack=%h expected %h", ack, expAck);
        end

    a_order: assert property (@(posedge clk) disable iff (rst)
        grantRise |-> waiting != '0 && grant == expGrant && recv == expRecv)
        else begin
            failCount++;
            $error("CHECK FAILED grant=%h recv=%h expected %h %h",
                   grant, recv, expGrant, expRecv);
        end

    a_freeGate: assert property (@(posedge clk) disable iff (rst)
        grantRise |-> (recv & prevFree) != '0)
        else begin
            failCount++;
            $error("CHECK FAILED recv=%h while free was %h", recv, prevFree);
        end

    a_release: assert property (@(posedge clk) disable iff (rst)
        prevGrant != '0 |-> grant == expHold && (grant == '0 || recv == prevRecv))
        else begin
            failCount++;
            $error("CHECK FAILED grant=%h expected %h recv=%h", grant, expHold, recv);
        end

    a_pairing: assert property (@(posedge clk) disable iff (rst)
        (grant == '0) == (recv == '0))
        else begin
            failCount++;
            $error("CHECK FAILED grant=%h recv=%h not paired", grant, recv);
        end

endmodule

// ==== test/busTopTb.sv ====
`timescale 1ns/1ns

module busTopTb import busPkg::*; ();

    localparam int          RandomCycles  = 2000;
    localparam int          TimeoutCycles = 2 * RandomCycles;
    localparam logic [1:0]  Idle          = 2'd0;
    localparam logic [1:0]  Asking        = 2'd1;   // req up, waiting for ack
    localparam logic [1:0]  Waiting       = 2'd2;   // Queued, waiting for grant
    localparam logic [1:0]  Holding       = 2'd3;   // Owns the bus

    logic                  clk;
    logic                  rst;
    logic [NumSenders-1:0] req = '0;
    logic [RecvIdx-1:0]    reqDest [NumSenders] = '{default: '0};
    logic [NumRecv-1:0]    free = '1;
    logic [NumSenders-1:0] rel = '0;
    logic [NumSenders-1:0] ack;
    logic [NumSenders-1:0] grant;
    logic [NumRecv-1:0]    recv;

    logic [1:0]            phase [NumSenders];
    int                    holdCnt [NumSenders];
    logic [NumSenders-1:0] start = '0;
    logic [RecvIdx-1:0]    startDest [NumSenders] = '{default: '0};
    logic [NumSenders-1:0] strayRel = '0;
    logic [NumRecv-1:0]    freeSet = '1;
    logic                  randMode = 1'b0;
    int                    fixedHold = 0;
    logic [31:0]           rngState = 32'h6f61;
    int                    cycleCount = 0;

    busTop i_dut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .reqDest (reqDest),
        .free    (free),
        .rel     (rel),
        .ack     (ack),
        .grant   (grant),
        .recv    (recv)
    );

    bind busTop busTopAssert i_chk (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .reqDest (reqDest),
        .free    (free),
        .rel     (rel),
        .ack     (ack),
        .grant   (grant),
        .recv    (recv)
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic mastersBusy();
        logic b;
        b = (grant != '0);
        for (int i = 0; i < NumSenders; i++) begin
            if (phase[i] != Idle) begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Each master follows the request rule and releases only while granted
    always @(posedge clk) begin
        logic [31:0] r;
        if (rst) begin
            for (int i = 0; i < NumSenders; i++) begin
                phase[i] <= Idle;
            end
            req <= '0;
            rel <= '0;
        end else begin
            for (int i = 0; i < NumSenders; i++) begin
                rngState = nextRandom(rngState);
                r = rngState;
                rel[i] <= 1'b0;
                case (phase[i])
                    Idle: begin
                        if (start[i] || (randMode && r[3:0] < 4'd3)) begin
                            req[i]     <= 1'b1;
                            reqDest[i] <= randMode ? RecvIdx'(r[31:8] % NumRecv) : startDest[i];
                            phase[i]   <= Asking;
                        end else if (!grant[i]) begin
                            rel[i] <= strayRel[i] || (randMode && r[7:4] == 4'd0);  // No effect
                        end
                    end
                    Asking: begin
                        if (ack[i]) begin
                            req[i]   <= 1'b0;
                            phase[i] <= Waiting;
                        end
                    end
                    Waiting: begin
                        if (grant[i]) begin
                            holdCnt[i] <= (fixedHold != 0) ? fixedHold : 1 + int'(r[2:0]);
                            phase[i]   <= Holding;
                        end
                    end
                    default: begin
                        if (holdCnt[i] <= 1) begin
                            rel[i]   <= 1'b1;
                            phase[i] <= Idle;
                        end else begin
                            holdCnt[i] <= holdCnt[i] - 1;
                        end
                    end
                endcase
            end
            rngState = nextRandom(rngState);
            free <= randMode ? (rngState[8:0] | rngState[20:12]) : freeSet;   // Mostly free
        end
    end

    task automatic launch(input logic [NumSenders-1:0] mask, input int offset);
        @(posedge clk);
        for (int i = 0; i < NumSenders; i++) begin
            startDest[i] <= RecvIdx'((i + offset) % NumRecv);
        end
        start <= mask;
        @(posedge clk);
        start <= '0;
    endtask

    task automatic waitIdle();
        while (mastersBusy()) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_chk.failCount != 0) begin
            $display("An assertion in the bus checker failed");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Run stopped on assertion failure");
        end
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (10) @(posedge clk);                 // Quiet bus after reset

        launch(11'h7ff, 3);                         // All at once, acks in falling index
        waitIdle();

        // Every receiver busy, queue fills and the rest wait for a slot
        @(posedge clk);
        freeSet <= '0;
        launch(11'h7ff, 0);
        repeat (20) @(posedge clk);
        freeSet <= '1;
        waitIdle();

        // Busy receiver 5 at the head blocks a request to receiver 2
        @(posedge clk);
        freeSet <= 9'h1df;
        launch(11'h400, 4);
        launch(11'h008, 8);
        repeat (15) @(posedge clk);
        freeSet <= '1;
        waitIdle();

        // Releases from idle masters while DMA owns the bus
        @(posedge clk);
        fixedHold <= 6;
        launch(11'h400, 0);
        while (!grant[10]) begin
            @(posedge clk);
        end
        strayRel <= 11'h3ff;
        @(posedge clk);
        strayRel <= '0;
        waitIdle();
        fixedHold <= 0;

        randMode <= 1'b1;
        repeat (RandomCycles) @(posedge clk);
        randMode <= 1'b0;
        freeSet  <= '1;
        waitIdle();
        repeat (4) @(posedge clk);

        if (i_dut.i_chk.failCount == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Assertion failures were counted");
        end
    end

endmodule

// ==== busTop.f ====
hdl/busPkg.sv
hdl/busReqQueue.sv
hdl/busAllocator.sv
hdl/busTop.sv
test/busTop_assert.sv
test/busTopTb.sv

// ==== Makefile ====
TOP := busTopTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): busTop.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal -f busTop.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then echo "No result in log"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f busTop.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
